// File: Makefile
VERILATOR ?= verilator
TOP       ?= api_tb
FLIST     ?= vlog.f
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "TB FAILED" $(LOG); then \
		echo "Simulation reported a failure, see $(LOG)"; \
		exit 1; \
	fi
	@if ! grep -q "TB PASSED" $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: api_ctrl/api_ctrl.sv
`timescale 1ns/1ps
`include "api_defs.svh"

module api_ctrl (
	input  logic                           clk,
	input  logic                           rst,
	output api_pkg::api_state_e            state,
	input  logic [27:0]                    reg_timeout,
	input  logic [7:0]                     reg_sck,
	input  logic [5:0]                     reg_ch_num,
	input  logic [7:0]                     reg_word_num,
	output logic                           tx_rd_en,
	input  logic [31:0]                    tx_dout,
	input  logic [$clog2(`API_TX_DEPTH):0] tx_count,
	output logic                           rx_wr_en,
	output api_pkg::api_rx_word_u          rx_din,
	input  logic [$clog2(`API_RX_DEPTH):0] rx_count,
	output logic [`API_NUM-1:0]            load,
	output logic                           sck,
	output logic                           mosi,
	input  logic [`API_NUM-1:0]            miso,
	output logic                           led_nonce_l,
	output logic                           led_nonce_h
);
	import api_pkg::*;

	localparam int RXCW = $clog2(`API_RX_DEPTH) + 1;
	localparam int PW = $clog2(`API_WORK_LEN);
	localparam int RX_RESERVE = `API_RX_BLOCK_LEN * `API_MAX_CHIP_IN_CH;
	localparam logic [PW-1:0] POS_LAST = PW'(`API_WORK_LEN - 1);
	localparam logic [PW-1:0] POS_TRAILER = PW'(`API_RX_BLOCK_LEN - 1);
	localparam logic [PW-1:0] POS_NONCE = PW'(2);
	localparam logic [3:0] NOP_LAST = 4'd14;

	api_state_e      nxt_state;
	logic            enter_work;
	logic            leave_nop;
	logic [27:0]     tmo_cnt;
	logic            tmo_busy;
	logic [RXCW-1:0] rx_free;
	logic            can_start;
	logic [7:0]      word_cnt;
	logic [PW-1:0]   pos_cnt;
	logic [5:0]      ch_cnt;
	logic [3:0]      nop_cnt;
	logic            mosi_vld;
	logic            miso_vld;
	logic [31:0]     miso_dat;
	logic            miso_sel;
	logic [3:0]      chip_id;
	logic            nonce_hit;

	assign tmo_busy = tmo_cnt != '0;
	assign rx_free = RXCW'(`API_RX_DEPTH) - rx_count;
	// Whole exchange must be buffered and its results must fit
	assign can_start = !tmo_busy && reg_word_num != '0 &&
		8'(tx_count) >= reg_word_num && rx_free >= RXCW'(RX_RESERVE);

	always_comb begin
		nxt_state = state;
		case (state)
			WAIT: if (can_start) nxt_state = WORK;
			WORK: if (word_cnt == reg_word_num) nxt_state = NOP;
			NOP: if (nop_cnt == NOP_LAST) nxt_state = WAIT;
			default: nxt_state = WAIT;
		endcase
	end

	assign enter_work = state == WAIT && nxt_state == WORK;
	assign leave_nop = state == NOP && nxt_state == WAIT;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= WAIT;
			tmo_cnt <= '0;
			word_cnt <= '0;
			pos_cnt <= '0;
			nop_cnt <= '0;
			mosi_vld <= 1'b0;
		end else begin
			state <= nxt_state;
			// Timeout restarts with every exchange
			if (enter_work) begin
				tmo_cnt <= reg_timeout;
			end else if (tmo_busy) begin
				tmo_cnt <= tmo_cnt - 28'd1;
			end
			if (enter_work) begin
				word_cnt <= '0;
				pos_cnt <= '0;
			end else if (state == WORK && miso_vld) begin
				word_cnt <= word_cnt + 8'd1;
				pos_cnt <= (pos_cnt == POS_LAST) ? '0 : pos_cnt + PW'(1);
			end
			nop_cnt <= (state == NOP) ? nop_cnt + 4'd1 : '0;
			// Next word goes out right after the previous one returns
			mosi_vld <= enter_work ||
				(state == WORK && miso_vld && word_cnt + 8'd1 < reg_word_num);
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			load <= ~`API_NUM'(1);
			ch_cnt <= '0;
		end else if (leave_nop) begin
			load <= {load[`API_NUM-2:0], load[`API_NUM-1]};
			ch_cnt <= (ch_cnt >= reg_ch_num) ? '0 : ch_cnt + 6'd1;
		end
	end

	assign tx_rd_en = mosi_vld;

	// Only the selected chip can pull the merged line low
	assign miso_sel = &(miso | load);

	always_comb begin
		chip_id = '0;
		for (int i = 0; i < `API_NUM; i++) begin
			if (!load[i]) chip_id = 4'(i);
		end
	end

	assign rx_wr_en = state == WORK && miso_vld && pos_cnt < PW'(`API_RX_BLOCK_LEN);

	always_comb begin
		rx_din.raw = miso_dat;
		if (pos_cnt == POS_TRAILER) begin
			rx_din.trailer.tag = `API_RESULT_TAG;
			rx_din.trailer.spare = '0;
			rx_din.trailer.chip_id = chip_id;
		end
	end

	// Nonce word split by channel half
	assign nonce_hit = rx_wr_en && pos_cnt == POS_NONCE && miso_dat != `API_EMPTY_NONCE;
	assign led_nonce_l = nonce_hit && ch_cnt <= 6'd4;
	assign led_nonce_h = nonce_hit && ch_cnt > 6'd4;

	api_phy api_phy_i (
		.clk      (clk),
		.rst      (rst),
		.reg_sck  (reg_sck),
		.mosi_vld (mosi_vld),
		.mosi_dat (tx_dout),
		.miso_vld (miso_vld),
		.miso_dat (miso_dat),
		.sck      (sck),
		.mosi     (mosi),
		.miso     (miso_sel)
	);

	a_load_onehot: assert property (@(posedge clk) disable iff (rst) $onehot(~load));

	// A word can only return after at least one full cycle in WORK
	a_rx_in_work: assert property (@(posedge clk) disable iff (rst)
		rx_wr_en |-> state == WORK && $past(state) == WORK);

endmodule

// File: api_ctrl/api_phy.sv
`timescale 1ns/1ps

module api_phy (
	input  logic        clk,
	input  logic        rst,
	input  logic [7:0]  reg_sck,
	input  logic        mosi_vld,
	input  logic [31:0] mosi_dat,
	output logic        miso_vld,
	output logic [31:0] miso_dat,
	output logic        sck,
	output logic        mosi,
	input  logic        miso
);
	logic        busy;
	logic [7:0]  div_cnt;
	logic [5:0]  edge_cnt;
	logic        tick;
	logic        last;
	logic        start;
	logic [31:0] tx_sh;
	logic [31:0] rx_sh;

	// One sck half period every reg_sck+1 clocks
	assign tick = busy && div_cnt == reg_sck;
	// 64th edge of sck ends the word
	assign last = tick && edge_cnt == 6'd63;
	assign start = mosi_vld && !busy;

	assign miso_vld = last;
	assign miso_dat = rx_sh;

	always_ff @(posedge clk) begin
		if (rst) begin
			busy <= 1'b0;
			div_cnt <= '0;
			edge_cnt <= '0;
			sck <= 1'b0;
			mosi <= 1'b0;
		end else if (start) begin
			busy <= 1'b1;
			div_cnt <= '0;
			edge_cnt <= '0;
			mosi <= mosi_dat[31];
		end else if (tick) begin
			div_cnt <= '0;
			edge_cnt <= edge_cnt + 6'd1;
			sck <= ~sck;
			if (last) begin
				busy <= 1'b0;
				mosi <= 1'b0;
			end else if (sck) begin
				// Falling edge, next bit out
				mosi <= tx_sh[30];
			end
		end else if (busy) begin
			div_cnt <= div_cnt + 8'd1;
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			tx_sh <= mosi_dat;
		end else if (tick && sck) begin
			tx_sh <= {tx_sh[30:0], 1'b0};
		end
		// Sample on the rising edge
		if (tick && !sck) begin
			rx_sh <= {rx_sh[30:0], miso};
		end
	end

	a_no_overlap: assert property (@(posedge clk) disable iff (rst) mosi_vld |-> !busy);

endmodule

// File: common/api_defs.svh
`ifndef API_DEFS_SVH
`define API_DEFS_SVH

// Chain and buffer sizes
`define API_NUM            10
`define API_RX_DEPTH       512
`define API_TX_DEPTH       64

// Exchange layout in 32-bit words
`define API_WORK_LEN       23
`define API_RX_BLOCK_LEN   11
`define API_MAX_CHIP_IN_CH 5

`define API_EMPTY_NONCE    32'hbeafbeaf
`define API_RESULT_TAG     8'h12

// APB register map, byte offsets
`define API_APB_AW         8
`define API_ADDR_STATE     8'h00
`define API_ADDR_TIMEOUT   8'h04
`define API_ADDR_SCK       8'h08
`define API_ADDR_CH_NUM    8'h0c
`define API_ADDR_WORD_NUM  8'h10
`define API_ADDR_TX_DATA   8'h14
`define API_ADDR_RX_DATA   8'h18
`define API_ADDR_RX_COUNT  8'h1c

`endif

// File: common/api_pkg.sv
package api_pkg;

	// Controller states
	typedef enum logic [1:0] {
		WAIT = 2'd0,
		WORK = 2'd1,
		NOP  = 2'd2
	} api_state_e;

	// Last word of a returned block, after retagging
	typedef struct packed {
		logic [15:0] nonce_hi;
		logic [7:0]  tag;
		logic [3:0]  spare;
		logic [3:0]  chip_id;
	} api_trailer_t;

	// Returned word, seen raw or as a trailer
	typedef union packed {
		logic [31:0]  raw;
		api_trailer_t trailer;
	} api_rx_word_u;

endpackage

// File: logic/api_fifo.sv
`timescale 1ns/1ps

module api_fifo #(
	parameter int DEPTH = 64,
	parameter int WIDTH = 32
) (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   wr_en,
	input  logic [WIDTH-1:0]       din,
	input  logic                   rd_en,
	output logic [WIDTH-1:0]       dout,
	output logic                   empty,
	output logic                   full,
	output logic [$clog2(DEPTH):0] count
);
	localparam int AW = $clog2(DEPTH);
	localparam logic [AW-1:0] PTR_ONE = AW'(1);
	localparam logic [AW-1:0] PTR_LAST = AW'(DEPTH - 1);
	localparam logic [AW:0] CNT_ONE = (AW+1)'(1);
	localparam logic [AW:0] CNT_FULL = (AW+1)'(DEPTH);

	logic [WIDTH-1:0] mem [DEPTH];
	logic [AW-1:0]    wr_ptr;
	logic [AW-1:0]    rd_ptr;
	logic             wr_ok;
	logic             rd_ok;

	assign wr_ok = wr_en && !full;
	assign rd_ok = rd_en && !empty;
	assign empty = count == '0;
	assign full = count == CNT_FULL;

	// First word falls through to the output
	assign dout = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (wr_ok) begin
			mem[wr_ptr] <= din;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (wr_ok) begin
				wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + PTR_ONE;
			end
			if (rd_ok) begin
				rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + PTR_ONE;
			end
			case ({wr_ok, rd_ok})
				2'b10: count <= count + CNT_ONE;
				2'b01: count <= count - CNT_ONE;
				default: count <= count;
			endcase
		end
	end

	a_count_bound: assert property (@(posedge clk) disable iff (rst) count <= CNT_FULL);

endmodule

// File: logic/api_regs.sv
`timescale 1ns/1ps
`include "api_defs.svh"

module api_regs (
	input  logic                           clk,
	input  logic                           rst,
	input  logic [`API_APB_AW-1:0]         paddr,
	input  logic                           psel,
	input  logic                           penable,
	input  logic                           pwrite,
	input  logic [31:0]                    pwdata,
	output logic [31:0]                    prdata,
	output logic                           pready,
	output logic                           pslverr,
	input  api_pkg::api_state_e            state,
	output logic [27:0]                    reg_timeout,
	output logic [7:0]                     reg_sck,
	output logic [5:0]                     reg_ch_num,
	output logic [7:0]                     reg_word_num,
	output logic                           tx_wr_en,
	output logic [31:0]                    tx_din,
	input  logic                           tx_full,
	output logic                           rx_rd_en,
	input  logic [31:0]                    rx_dout,
	input  logic                           rx_empty,
	input  logic [$clog2(`API_RX_DEPTH):0] rx_count
);
	logic access;
	logic wr_acc;
	logic rd_acc;
	logic mapped;
	logic tx_sel;
	logic rx_sel;

	// No wait states
	assign access = psel && penable;
	assign wr_acc = access && pwrite;
	assign rd_acc = access && !pwrite;
	assign pready = access;

	assign tx_sel = paddr == `API_ADDR_TX_DATA;
	assign rx_sel = paddr == `API_ADDR_RX_DATA;

	always_comb begin
		case (paddr)
			`API_ADDR_STATE, `API_ADDR_TIMEOUT, `API_ADDR_SCK, `API_ADDR_CH_NUM,
			`API_ADDR_WORD_NUM, `API_ADDR_TX_DATA, `API_ADDR_RX_DATA,
			`API_ADDR_RX_COUNT: mapped = 1'b1;
			default: mapped = 1'b0;
		endcase
	end

	// Data ports turn into single-cycle FIFO strobes
	assign tx_wr_en = wr_acc && tx_sel && !tx_full;
	assign tx_din = pwdata;
	assign rx_rd_en = rd_acc && rx_sel && !rx_empty;

	assign pslverr = access && (!mapped || (pwrite && tx_sel && tx_full) ||
		(!pwrite && rx_sel && rx_empty));

	always_ff @(posedge clk) begin
		if (rst) begin
			reg_timeout <= 28'd1000;
			reg_sck <= 8'd1;
			reg_ch_num <= 6'd9;
			reg_word_num <= 8'(`API_WORK_LEN);
		end else if (wr_acc) begin
			case (paddr)
				`API_ADDR_TIMEOUT: reg_timeout <= pwdata[27:0];
				`API_ADDR_SCK: reg_sck <= pwdata[7:0];
				`API_ADDR_CH_NUM: reg_ch_num <= pwdata[5:0];
				`API_ADDR_WORD_NUM: reg_word_num <= pwdata[7:0];
				default: ;
			endcase
		end
	end

	// Read data, valid during the access cycle
	always_comb begin
		case (paddr)
			`API_ADDR_STATE: prdata = 32'(state);
			`API_ADDR_TIMEOUT: prdata = 32'(reg_timeout);
			`API_ADDR_SCK: prdata = 32'(reg_sck);
			`API_ADDR_CH_NUM: prdata = 32'(reg_ch_num);
			`API_ADDR_WORD_NUM: prdata = 32'(reg_word_num);
			`API_ADDR_RX_DATA: prdata = rx_empty ? '0 : rx_dout;
			`API_ADDR_RX_COUNT: prdata = 32'(rx_count);
			default: prdata = '0;
		endcase
	end

	a_apb_enable: assert property (@(posedge clk) disable iff (rst) penable |-> psel);

endmodule

// File: logic/api_top.sv
`timescale 1ns/1ps
`include "api_defs.svh"

module api_top (
	input  logic                   clk,
	input  logic                   rst,
	input  logic [`API_APB_AW-1:0] paddr,
	input  logic                   psel,
	input  logic                   penable,
	input  logic                   pwrite,
	input  logic [31:0]            pwdata,
	output logic [31:0]            prdata,
	output logic                   pready,
	output logic                   pslverr,
	output logic [`API_NUM-1:0]    load,
	output logic                   sck,
	output logic                   mosi,
	input  logic [`API_NUM-1:0]    miso,
	output logic                   led_nonce_l,
	output logic                   led_nonce_h
);
	import api_pkg::*;

	localparam int TXCW = $clog2(`API_TX_DEPTH) + 1;
	localparam int RXCW = $clog2(`API_RX_DEPTH) + 1;

	api_state_e    state;
	logic [27:0]   reg_timeout;
	logic [7:0]    reg_sck;
	logic [5:0]    reg_ch_num;
	logic [7:0]    reg_word_num;
	logic          tx_wr_en;
	logic [31:0]   tx_din;
	logic          tx_full;
	logic          tx_rd_en;
	logic [31:0]   tx_dout;
	logic [TXCW-1:0] tx_count;
	logic          rx_wr_en;
	api_rx_word_u  rx_din;
	logic          rx_rd_en;
	logic [31:0]   rx_dout;
	logic          rx_empty;
	logic [RXCW-1:0] rx_count;

	api_regs api_regs_i (
		.clk          (clk),
		.rst          (rst),
		.paddr        (paddr),
		.psel         (psel),
		.penable      (penable),
		.pwrite       (pwrite),
		.pwdata       (pwdata),
		.prdata       (prdata),
		.pready       (pready),
		.pslverr      (pslverr),
		.state        (state),
		.reg_timeout  (reg_timeout),
		.reg_sck      (reg_sck),
		.reg_ch_num   (reg_ch_num),
		.reg_word_num (reg_word_num),
		.tx_wr_en     (tx_wr_en),
		.tx_din       (tx_din),
		.tx_full      (tx_full),
		.rx_rd_en     (rx_rd_en),
		.rx_dout      (rx_dout),
		.rx_empty     (rx_empty),
		.rx_count     (rx_count)
	);

	// Host to chips
	api_fifo #(.DEPTH(`API_TX_DEPTH), .WIDTH(32)) tx_fifo (
		.clk   (clk),
		.rst   (rst),
		.wr_en (tx_wr_en),
		.din   (tx_din),
		.rd_en (tx_rd_en),
		.dout  (tx_dout),
		.empty (),
		.full  (tx_full),
		.count (tx_count)
	);

	// Chips to host
	api_fifo #(.DEPTH(`API_RX_DEPTH), .WIDTH(32)) rx_fifo (
		.clk   (clk),
		.rst   (rst),
		.wr_en (rx_wr_en),
		.din   (rx_din.raw),
		.rd_en (rx_rd_en),
		.dout  (rx_dout),
		.empty (rx_empty),
		.full  (),
		.count (rx_count)
	);

	api_ctrl api_ctrl_i (
		.clk          (clk),
		.rst          (rst),
		.state        (state),
		.reg_timeout  (reg_timeout),
		.reg_sck      (reg_sck),
		.reg_ch_num   (reg_ch_num),
		.reg_word_num (reg_word_num),
		.tx_rd_en     (tx_rd_en),
		.tx_dout      (tx_dout),
		.tx_count     (tx_count),
		.rx_wr_en     (rx_wr_en),
		.rx_din       (rx_din),
		.rx_count     (rx_count),
		.load         (load),
		.sck          (sck),
		.mosi         (mosi),
		.miso         (miso),
		.led_nonce_l  (led_nonce_l),
		.led_nonce_h  (led_nonce_h)
	);

endmodule

// File: verif/api_chip_model.sv
`timescale 1ns/1ps
`include "api_defs.svh"

module api_chip_model (
	input  logic                rst,
	input  logic                sck,
	input  logic [`API_NUM-1:0] load,
	output logic [`API_NUM-1:0] miso
);

	// Word n of an exchange with chip k
	function automatic logic [31:0] reply_word(input int k, input logic [15:0] n);
		if (n == 16'd2 && k % 2 == 0) begin
			return `API_EMPTY_NONCE;
		end
		return {4'(k), 12'h000, n};
	endfunction

	for (genvar k = 0; k < `API_NUM; k++) begin : g_chip
		logic [4:0]  bit_cnt = '0;
		logic [15:0] word_cnt = '0;
		logic [31:0] cur;

		assign cur = reply_word(k, word_cnt);
		// Deselected chips leave their line high
		assign miso[k] = load[k] | cur[5'd31 - bit_cnt];

		// Next bit goes out on the falling edge of sck
		always @(negedge sck) begin
			if (rst || load[k]) begin
				bit_cnt <= '0;
				word_cnt <= '0;
			end else begin
				bit_cnt <= bit_cnt + 5'd1;
				if (bit_cnt == 5'd31) begin
					word_cnt <= word_cnt + 16'd1;
				end
			end
		end
	end

endmodule

// File: verif/api_tb.sv
`timescale 1ns/1ps
`include "api_defs.svh"

module api_tb;
	import api_pkg::*;

	// Seven exchanges of about 3000 cycles each, plus APB traffic
	localparam int CYCLE_LIMIT = 200000;
	localparam logic [`API_NUM-1:0] ODD_CHIPS = {(`API_NUM / 2){2'b10}};

	logic                   clk;
	logic                   rst;
	logic [`API_APB_AW-1:0] paddr;
	logic                   psel;
	logic                   penable;
	logic                   pwrite;
	logic [31:0]            pwdata;
	logic [31:0]            prdata;
	logic                   pready;
	logic                   pslverr;
	logic [`API_NUM-1:0]    load;
	logic [`API_NUM-1:0]    miso;
	logic                   sck;
	logic                   mosi;
	logic                   led_nonce_l;
	logic                   led_nonce_h;

	int errors;
	int tests_passed;
	int tests_failed;
	int cycles;
	int led_l_seen;
	int led_h_seen;
	int mosi_bits;
	logic [31:0] mosi_sh;
	logic [31:0] sent_q [$];

	api_top api_top_i (
		.clk         (clk),
		.rst         (rst),
		.paddr       (paddr),
		.psel        (psel),
		.penable     (penable),
		.pwrite      (pwrite),
		.pwdata      (pwdata),
		.prdata      (prdata),
		.pready      (pready),
		.pslverr     (pslverr),
		.load        (load),
		.sck         (sck),
		.mosi        (mosi),
		.miso        (miso),
		.led_nonce_l (led_nonce_l),
		.led_nonce_h (led_nonce_h)
	);

	api_chip_model api_chip_model_i (
		.rst  (rst),
		.sck  (sck),
		.load (load),
		.miso (miso)
	);

	always #5 clk = ~clk;

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Timeout: the run did not finish within %0d clock cycles", CYCLE_LIMIT);
			$display("TB FAILED");
			$finish;
		end
	end

	always @(posedge clk) begin
		if (!rst && led_nonce_l) led_l_seen <= led_l_seen + 1;
		if (!rst && led_nonce_h) led_h_seen <= led_h_seen + 1;
	end

	// Work words leave on mosi in push order, msb first
	always @(posedge sck) begin
		mosi_sh = {mosi_sh[30:0], mosi};
		mosi_bits++;
		if (mosi_bits == 32) begin
			mosi_bits = 0;
			assert (sent_q.size() != 0 && mosi_sh == sent_q[0]) else
				report_mismatch($sformatf("mosi word %h does not match pushed work", mosi_sh));
			if (sent_q.size() != 0) begin
				void'(sent_q.pop_front());
			end
		end
	end

	function automatic void report_mismatch(input string msg);
		errors++;
		$display("FAIL %0t: %s", $time, msg);
	endfunction

	// Reply rule of the chip chain
	function automatic logic [31:0] expected_word(input int chip, input int n);
		if (n == 2 && chip % 2 == 0) begin
			return `API_EMPTY_NONCE;
		end
		return {4'(chip), 12'h000, 16'(n)};
	endfunction

	task automatic finish_test(input int num, input string name, input int errs_before);
		if (errors == errs_before) begin
			tests_passed++;
			$display("test %0d %s: PASS", num, name);
		end else begin
			tests_failed++;
			$display("test %0d %s: FAIL with %0d errors", num, name, errors - errs_before);
		end
	endtask

	task automatic apb_write(input logic [7:0] addr, input logic [31:0] data, output logic err);
		@(posedge clk);
		paddr <= addr;
		pwdata <= data;
		pwrite <= 1'b1;
		psel <= 1'b1;
		@(posedge clk);
		penable <= 1'b1;
		@(negedge clk);
		err = pslverr;
		@(posedge clk);
		psel <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic apb_read(input logic [7:0] addr, output logic [31:0] data, output logic err);
		@(posedge clk);
		paddr <= addr;
		pwrite <= 1'b0;
		psel <= 1'b1;
		@(posedge clk);
		penable <= 1'b1;
		// Read data settles in the middle of the access cycle
		@(negedge clk);
		data = prdata;
		err = pslverr;
		@(posedge clk);
		psel <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
		logic err;
		apb_write(addr, data, err);
		assert (!err) else report_mismatch($sformatf("pslverr on write to %h", addr));
	endtask

	task automatic write_read_back(input logic [7:0] addr, input logic [31:0] data);
		logic [31:0] got;
		logic err;
		write_reg(addr, data);
		apb_read(addr, got, err);
		assert (!err && got == data) else
			report_mismatch($sformatf("register %h read %h, expected %h", addr, got, data));
	endtask

	task automatic push_work(input int count);
		logic [31:0] w;
		for (int i = 0; i < count; i++) begin
			w = $urandom();
			sent_q.push_back(w);
			write_reg(`API_ADDR_TX_DATA, w);
		end
	endtask

	task automatic wait_rx_words(input int n);
		logic [31:0] cnt;
		logic err;
		cnt = '0;
		while (cnt < 32'(n)) begin
			apb_read(`API_ADDR_RX_COUNT, cnt, err);
		end
	endtask

	task automatic wait_idle();
		logic [31:0] st;
		logic err;
		st = 32'hffff_ffff;
		while (st != 32'(WAIT)) begin
			apb_read(`API_ADDR_STATE, st, err);
		end
	endtask

	// One result block from the given chip
	task automatic read_block(input int chip);
		logic [31:0]  data;
		logic [31:0]  exp;
		logic         err;
		api_rx_word_u word;
		wait_rx_words(`API_RX_BLOCK_LEN);
		for (int n = 0; n < `API_RX_BLOCK_LEN - 1; n++) begin
			apb_read(`API_ADDR_RX_DATA, data, err);
			exp = expected_word(chip, n);
			assert (!err && data == exp) else
				report_mismatch($sformatf("chip %0d word %0d read %h, expected %h",
					chip, n, data, exp));
		end
		apb_read(`API_ADDR_RX_DATA, data, err);
		word.raw = data;
		exp = expected_word(chip, `API_RX_BLOCK_LEN - 1);
		assert (!err && word.trailer.tag == 8'h12 && word.trailer.chip_id == 4'(chip) &&
			word.trailer.nonce_hi == exp[31:16]) else
			report_mismatch($sformatf("chip %0d trailer %h, tag %h chip_id %0d",
				chip, data, word.trailer.tag, word.trailer.chip_id));
	endtask

	a_one_load: assert property (@(posedge clk) disable iff (rst) $onehot(~load))
		else report_mismatch("load is not one-hot low");

	// Even chips return the empty marker, so no strobe
	a_led_odd: assert property (@(posedge clk) disable iff (rst)
		(led_nonce_l || led_nonce_h) |-> (~load & ODD_CHIPS) != '0)
		else report_mismatch("nonce strobe during an exchange with an even chip");

	a_pready: assert property (@(posedge clk) disable iff (rst) (psel && penable) |-> pready)
		else report_mismatch("pready low in an APB access cycle");

	initial begin
		logic [31:0] data;
		logic        err;
		int          mark;
		int          led_l0;
		int          led_h0;
		int          exp_l;
		int          exp_h;

		clk = 1'b0;
		rst = 1'b1;
		paddr = '0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		pwdata = '0;
		errors = 0;
		tests_passed = 0;
		tests_failed = 0;
		cycles = 0;
		led_l_seen = 0;
		led_h_seen = 0;
		mosi_bits = 0;
		mosi_sh = '0;
		void'($urandom(32'hb2d0_5af6));
		repeat (16) @(posedge clk);
		rst <= 1'b0;

		mark = errors;
		apb_read(`API_ADDR_STATE, data, err);
		assert (!err && data == 32'(WAIT)) else
			report_mismatch($sformatf("state after reset reads %0d", data));
		write_read_back(`API_ADDR_TIMEOUT, 32'h0abc_def1);
		write_read_back(`API_ADDR_SCK, 32'h0000_005a);
		write_read_back(`API_ADDR_CH_NUM, 32'h0000_002b);
		write_read_back(`API_ADDR_WORD_NUM, 32'h0000_0040);
		apb_read(8'h20, data, err);
		assert (err) else report_mismatch("no pslverr on read of unmapped address");
		apb_write(8'h24, 32'h1234_5678, err);
		assert (err) else report_mismatch("no pslverr on write to unmapped address");
		apb_read(`API_ADDR_RX_COUNT, data, err);
		assert (!err && data == '0) else
			report_mismatch($sformatf("receive count after reset reads %0d", data));
		write_reg(`API_ADDR_TIMEOUT, 32'd1000);
		write_reg(`API_ADDR_SCK, 32'd1);
		write_reg(`API_ADDR_CH_NUM, 32'd9);
		write_reg(`API_ADDR_WORD_NUM, 32'(`API_WORK_LEN));
		finish_test(1, "register access", mark);

		mark = errors;
		push_work(`API_WORK_LEN);
		read_block(0);
		finish_test(2, "single exchange", mark);

		mark = errors;
		push_work(`API_WORK_LEN);
		read_block(1);
		push_work(`API_WORK_LEN);
		read_block(2);
		finish_test(3, "load rotation", mark);

		// Channel counter follows the chip up to 9, so chip 5 is in the upper half
		mark = errors;
		write_reg(`API_ADDR_CH_NUM, 32'd9);
		for (int chip = 3; chip <= 5; chip++) begin
			led_l0 = led_l_seen;
			led_h0 = led_h_seen;
			push_work(`API_WORK_LEN);
			read_block(chip);
			exp_l = (chip % 2 == 1 && chip <= 4) ? 1 : 0;
			exp_h = (chip % 2 == 1 && chip > 4) ? 1 : 0;
			assert (led_l_seen - led_l0 == exp_l && led_h_seen - led_h0 == exp_h) else
				report_mismatch($sformatf("chip %0d strobes low %0d high %0d, expected %0d %0d",
					chip, led_l_seen - led_l0, led_h_seen - led_h0, exp_l, exp_h));
		end
		finish_test(4, "LED strobes", mark);

		mark = errors;
		wait_idle();
		push_work(10);
		repeat (300) @(posedge clk);
		apb_read(`API_ADDR_STATE, data, err);
		assert (data == 32'(WAIT)) else
			report_mismatch($sformatf("state %0d with too few transmit words", data));
		apb_read(`API_ADDR_RX_COUNT, data, err);
		assert (data == '0) else
			report_mismatch($sformatf("receive count %0d with too few transmit words", data));
		push_work(`API_WORK_LEN - 10);
		read_block(6);
		finish_test(5, "back-pressure", mark);

		mark = errors;
		wait_idle();
		apb_read(`API_ADDR_RX_DATA, data, err);
		assert (err && data == '0) else
			report_mismatch($sformatf("empty receive read gave %h, pslverr %b", data, err));
		// Word count above the FIFO depth keeps the controller idle
		write_reg(`API_ADDR_WORD_NUM, 32'd255);
		push_work(`API_TX_DEPTH);
		apb_write(`API_ADDR_TX_DATA, 32'hdead_0001, err);
		assert (err) else report_mismatch("no pslverr on write to full transmit FIFO");
		finish_test(6, "error handling", mark);

		$display("tests passed %0d, tests failed %0d, errors %0d",
			tests_passed, tests_failed, errors);
		if (errors == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

// File: vlog.f
+incdir+common
common/api_pkg.sv
logic/api_fifo.sv
api_ctrl/api_phy.sv
api_ctrl/api_ctrl.sv
logic/api_regs.sv
logic/api_top.sv
verif/api_chip_model.sv
verif/api_tb.sv
